// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

////////////////////
// Datapath sizing
////////////////////

// One machine word, also the pc width
`define CPU_XLEN 32

// Architectural register count
`define CPU_NREG 32

// Bits needed to name one register
`define CPU_RIDX_W 5

`endif

// File: source/cpu_pkg.sv
package cpu_pkg;

	////////////////////
	// Instruction fields
	////////////////////

	// Primary opcode, bits 31:26
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05,
		OP_ADDI  = 6'h08,
		OP_ORI   = 6'h0d,
		OP_LUI   = 6'h0f
	} opcode_e;

	// R-type function code, bits 5:0
	typedef enum logic [5:0] {
		FN_SLL = 6'h00,
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_XOR = 6'h26,
		FN_SLT = 6'h2a
	} funct_e;

	////////////////////
	// Execute control
	////////////////////

	// ALU_ADD must stay at zero, it is the cleared value of ID/EXE
	typedef enum logic [3:0] {
		ALU_ADD = 4'd0,
		ALU_SUB = 4'd1,
		ALU_AND = 4'd2,
		ALU_OR  = 4'd3,
		ALU_XOR = 4'd4,
		ALU_SLT = 4'd5,
		ALU_SLL = 4'd6,
		ALU_LUI = 4'd7
	} alu_op_e;

endpackage

// File: source/reg_file.sv
`include "cpu_settings.svh"

module reg_file (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [`CPU_RIDX_W-1:0] ra_idx,
	input  logic [`CPU_RIDX_W-1:0] rb_idx,
	input  logic                   we,
	input  logic [`CPU_RIDX_W-1:0] w_idx,
	input  logic [`CPU_XLEN-1:0]   w_data,
	output logic [`CPU_XLEN-1:0]   ra_data,
	output logic [`CPU_XLEN-1:0]   rb_data
);

	logic [`CPU_XLEN-1:0] regs [`CPU_NREG];

	// Write port, entry 0 never changes so it reads as zero
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < `CPU_NREG; i++) begin
				regs[i] <= '0;
			end
		end else if (we && (w_idx != '0)) begin
			regs[w_idx] <= w_data;
		end
	end

	// Read ports are combinational
	// Same-cycle write data reaches ID through the WB forward path instead
	assign ra_data = regs[ra_idx];
	assign rb_data = regs[rb_idx];

endmodule

// File: source/decode_unit.sv
`include "cpu_settings.svh"

module decode_unit (
	input  logic [31:0]             instr,
	input  logic                    instr_valid,
	input  logic [`CPU_XLEN-1:0]    rf_ra_data,
	input  logic [`CPU_XLEN-1:0]    rf_rb_data,
	input  logic                    exe_fwd_we,
	input  logic [`CPU_RIDX_W-1:0]  exe_fwd_reg,
	input  logic [`CPU_XLEN-1:0]    exe_fwd_data,
	input  logic                    wb_we,
	input  logic [`CPU_RIDX_W-1:0]  wb_reg,
	input  logic [`CPU_XLEN-1:0]    wb_data,
	output logic [`CPU_RIDX_W-1:0]  rf_ra_idx,
	output logic [`CPU_RIDX_W-1:0]  rf_rb_idx,
	output cpu_pkg::alu_op_e        alu_op,
	output logic [`CPU_XLEN-1:0]    rega,
	output logic [`CPU_XLEN-1:0]    regb,
	output logic [15:0]             imme,
	output logic                    use_imm,
	output logic                    sign_ext,
	output logic                    is_branch,
	output logic                    branch_ne,
	output logic                    dreg_we,
	output logic [`CPU_RIDX_W-1:0]  dreg
);

	cpu_pkg::opcode_e       opcode;
	cpu_pkg::funct_e        funct;
	logic [`CPU_RIDX_W-1:0] rs;
	logic [`CPU_RIDX_W-1:0] rt;
	logic [`CPU_RIDX_W-1:0] rd;
	logic                   writes;

	////////////////////
	// Field split
	////////////////////

	assign opcode = cpu_pkg::opcode_e'(instr[31:26]);
	assign funct  = cpu_pkg::funct_e'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	// Shamt of sll rides along in imme[10:6]
	assign imme = instr[15:0];

	assign rf_ra_idx = rs;
	assign rf_rb_idx = rt;

	////////////////////
	// Control
	////////////////////

	always_comb begin
		alu_op    = cpu_pkg::ALU_ADD;
		use_imm   = 1'b0;
		sign_ext  = 1'b0;
		is_branch = 1'b0;
		branch_ne = 1'b0;
		writes    = 1'b0;
		dreg      = '0;
		if (instr_valid) begin
			case (opcode)
				cpu_pkg::OP_RTYPE: begin
					writes = 1'b1;
					dreg   = rd;
					case (funct)
						cpu_pkg::FN_ADD: alu_op = cpu_pkg::ALU_ADD;
						cpu_pkg::FN_SUB: alu_op = cpu_pkg::ALU_SUB;
						cpu_pkg::FN_AND: alu_op = cpu_pkg::ALU_AND;
						cpu_pkg::FN_OR:  alu_op = cpu_pkg::ALU_OR;
						cpu_pkg::FN_XOR: alu_op = cpu_pkg::ALU_XOR;
						cpu_pkg::FN_SLT: alu_op = cpu_pkg::ALU_SLT;
						cpu_pkg::FN_SLL: alu_op = cpu_pkg::ALU_SLL;
						default: begin
							writes = 1'b0;
							dreg   = '0;
						end
					endcase
				end
				cpu_pkg::OP_ADDI: begin
					use_imm  = 1'b1;
					sign_ext = 1'b1;
					writes   = 1'b1;
					dreg     = rt;
				end
				cpu_pkg::OP_ORI: begin
					alu_op  = cpu_pkg::ALU_OR;
					use_imm = 1'b1;
					writes  = 1'b1;
					dreg    = rt;
				end
				cpu_pkg::OP_LUI: begin
					alu_op  = cpu_pkg::ALU_LUI;
					use_imm = 1'b1;
					writes  = 1'b1;
					dreg    = rt;
				end
				cpu_pkg::OP_BEQ: begin
					is_branch = 1'b1;
				end
				cpu_pkg::OP_BNE: begin
					is_branch = 1'b1;
					branch_ne = 1'b1;
				end
				default: begin
				end
			endcase
		end
	end

	// A write to r0 is dropped here so no later stage sees it
	assign dreg_we = writes && (dreg != '0);

	////////////////////
	// Operand forwarding
	////////////////////

	// EXE result wins over WB, WB wins over the register file
	function automatic logic [`CPU_XLEN-1:0] fwd_pick(
		input logic [`CPU_RIDX_W-1:0] idx,
		input logic [`CPU_XLEN-1:0]   rf_val,
		input logic                   e_we,
		input logic [`CPU_RIDX_W-1:0] e_reg,
		input logic [`CPU_XLEN-1:0]   e_val,
		input logic                   w_we,
		input logic [`CPU_RIDX_W-1:0] w_reg,
		input logic [`CPU_XLEN-1:0]   w_val
	);
		logic [`CPU_XLEN-1:0] pick;
		pick = rf_val;
		if (idx != '0) begin
			if (e_we && (e_reg == idx)) begin
				pick = e_val;
			end else if (w_we && (w_reg == idx)) begin
				pick = w_val;
			end
		end
		return pick;
	endfunction

	assign rega = fwd_pick(rs, rf_ra_data, exe_fwd_we, exe_fwd_reg, exe_fwd_data,
		wb_we, wb_reg, wb_data);
	assign regb = fwd_pick(rt, rf_rb_data, exe_fwd_we, exe_fwd_reg, exe_fwd_data,
		wb_we, wb_reg, wb_data);

endmodule

// File: source/id_exe_reg.sv
`include "cpu_settings.svh"

module id_exe_reg (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   en,
	input  logic                   bubble,
	input  cpu_pkg::alu_op_e       id_alu_op,
	input  logic [`CPU_XLEN-1:0]   id_rega,
	input  logic [`CPU_XLEN-1:0]   id_regb,
	input  logic [15:0]            id_imme,
	input  logic                   id_use_imm,
	input  logic                   id_sign_ext,
	input  logic                   id_is_branch,
	input  logic                   id_branch_ne,
	input  logic                   id_dreg_we,
	input  logic [`CPU_RIDX_W-1:0] id_dreg,
	input  logic [`CPU_XLEN-1:0]   id_pc,
	output cpu_pkg::alu_op_e       exe_alu_op,
	output logic [`CPU_XLEN-1:0]   exe_rega,
	output logic [`CPU_XLEN-1:0]   exe_regb,
	output logic [15:0]            exe_imme,
	output logic                   exe_use_imm,
	output logic                   exe_sign_ext,
	output logic                   exe_is_branch,
	output logic                   exe_branch_ne,
	output logic                   exe_dreg_we,
	output logic [`CPU_RIDX_W-1:0] exe_dreg,
	output logic [`CPU_XLEN-1:0]   exe_pc
);

	////////////////////
	// Control and operands
	////////////////////

	// Bubble turns the stage into a no-op, even without en
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			exe_alu_op    <= cpu_pkg::ALU_ADD;
			exe_rega      <= '0;
			exe_regb      <= '0;
			exe_imme      <= '0;
			exe_use_imm   <= 1'b0;
			exe_sign_ext  <= 1'b0;
			exe_is_branch <= 1'b0;
			exe_branch_ne <= 1'b0;
			exe_dreg_we   <= 1'b0;
			exe_dreg      <= '0;
		end else if (bubble) begin
			exe_alu_op    <= cpu_pkg::ALU_ADD;
			exe_rega      <= '0;
			exe_regb      <= '0;
			exe_imme      <= '0;
			exe_use_imm   <= 1'b0;
			exe_sign_ext  <= 1'b0;
			exe_is_branch <= 1'b0;
			exe_branch_ne <= 1'b0;
			exe_dreg_we   <= 1'b0;
			exe_dreg      <= '0;
		end else if (en) begin
			exe_alu_op    <= id_alu_op;
			exe_rega      <= id_rega;
			exe_regb      <= id_regb;
			exe_imme      <= id_imme;
			exe_use_imm   <= id_use_imm;
			exe_sign_ext  <= id_sign_ext;
			exe_is_branch <= id_is_branch;
			exe_branch_ne <= id_branch_ne;
			exe_dreg_we   <= id_dreg_we;
			exe_dreg      <= id_dreg;
		end
	end

	////////////////////
	// Branch base
	////////////////////

	// Not touched by bubble
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			exe_pc <= '0;
		end else if (en) begin
			exe_pc <= id_pc;
		end
	end

endmodule

// File: source/exe_unit.sv
`include "cpu_settings.svh"

module exe_unit (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   hold,
	input  cpu_pkg::alu_op_e       exe_alu_op,
	input  logic [`CPU_XLEN-1:0]   exe_rega,
	input  logic [`CPU_XLEN-1:0]   exe_regb,
	input  logic [15:0]            exe_imme,
	input  logic                   exe_use_imm,
	input  logic                   exe_sign_ext,
	input  logic                   exe_is_branch,
	input  logic                   exe_branch_ne,
	input  logic                   exe_dreg_we,
	input  logic [`CPU_RIDX_W-1:0] exe_dreg,
	input  logic [`CPU_XLEN-1:0]   exe_pc,
	output logic                   fwd_we,
	output logic [`CPU_RIDX_W-1:0] fwd_reg,
	output logic [`CPU_XLEN-1:0]   fwd_data,
	output logic                   redirect,
	output logic [`CPU_XLEN-1:0]   redirect_pc,
	output logic                   wb_valid,
	output logic [`CPU_RIDX_W-1:0] wb_reg,
	output logic [`CPU_XLEN-1:0]   wb_data
);

	localparam logic [`CPU_XLEN-1:0] pc_step = 4;

	logic [`CPU_XLEN-1:0] imm_sx;
	logic [`CPU_XLEN-1:0] imm_zx;
	logic [`CPU_XLEN-1:0] op_b;
	logic [`CPU_XLEN-1:0] result;
	logic                 equal;
	logic                 taken;

	////////////////////
	// ALU
	////////////////////

	assign imm_sx = {{(`CPU_XLEN-16){exe_imme[15]}}, exe_imme};
	assign imm_zx = {{(`CPU_XLEN-16){1'b0}}, exe_imme};
	assign op_b   = exe_use_imm ? (exe_sign_ext ? imm_sx : imm_zx) : exe_regb;

	always_comb begin
		case (exe_alu_op)
			cpu_pkg::ALU_SUB: result = exe_rega - op_b;
			cpu_pkg::ALU_AND: result = exe_rega & op_b;
			cpu_pkg::ALU_OR:  result = exe_rega | op_b;
			cpu_pkg::ALU_XOR: result = exe_rega ^ op_b;
			cpu_pkg::ALU_SLT: begin
				result = {{(`CPU_XLEN-1){1'b0}}, ($signed(exe_rega) < $signed(op_b))};
			end
			// Shift amount is the shamt field, rt is the source
			cpu_pkg::ALU_SLL: result = op_b << exe_imme[10:6];
			cpu_pkg::ALU_LUI: result = {op_b[15:0], 16'h0000};
			default:          result = exe_rega + op_b;
		endcase
	end

	// Result visible to ID in the same cycle
	assign fwd_we   = exe_dreg_we;
	assign fwd_reg  = exe_dreg;
	assign fwd_data = result;

	////////////////////
	// Branch resolve
	////////////////////

	assign equal = (exe_rega == exe_regb);
	assign taken = exe_branch_ne ? !equal : equal;

	// Held back while hold is high, the branch stays in EXE until then
	assign redirect    = exe_is_branch && taken && !hold;
	assign redirect_pc = exe_pc + pc_step + {imm_sx[`CPU_XLEN-3:0], 2'b00};

	////////////////////
	// EXE/WB register
	////////////////////

	// A held instruction is still in EXE next cycle, so report it only once
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= exe_dreg_we && !hold;
		end
	end

	always_ff @(posedge clk) begin
		wb_reg  <= exe_dreg;
		wb_data <= result;
	end

endmodule

// File: source/pipe_core.sv
`include "cpu_settings.svh"

module pipe_core (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [31:0]            instr,
	input  logic [`CPU_XLEN-1:0]   instr_pc,
	input  logic                   instr_valid,
	input  logic                   hold,
	output logic                   redirect,
	output logic [`CPU_XLEN-1:0]   redirect_pc,
	output logic                   wb_valid,
	output logic [`CPU_RIDX_W-1:0] wb_reg,
	output logic [`CPU_XLEN-1:0]   wb_data
);

	// Register file ports
	logic [`CPU_RIDX_W-1:0] rf_ra_idx;
	logic [`CPU_RIDX_W-1:0] rf_rb_idx;
	logic [`CPU_XLEN-1:0]   rf_ra_data;
	logic [`CPU_XLEN-1:0]   rf_rb_data;

	// Decode outputs
	cpu_pkg::alu_op_e       id_alu_op;
	logic [`CPU_XLEN-1:0]   id_rega;
	logic [`CPU_XLEN-1:0]   id_regb;
	logic [15:0]            id_imme;
	logic                   id_use_imm;
	logic                   id_sign_ext;
	logic                   id_is_branch;
	logic                   id_branch_ne;
	logic                   id_dreg_we;
	logic [`CPU_RIDX_W-1:0] id_dreg;

	// ID/EXE contents
	cpu_pkg::alu_op_e       exe_alu_op;
	logic [`CPU_XLEN-1:0]   exe_rega;
	logic [`CPU_XLEN-1:0]   exe_regb;
	logic [15:0]            exe_imme;
	logic                   exe_use_imm;
	logic                   exe_sign_ext;
	logic                   exe_is_branch;
	logic                   exe_branch_ne;
	logic                   exe_dreg_we;
	logic [`CPU_RIDX_W-1:0] exe_dreg;
	logic [`CPU_XLEN-1:0]   exe_pc;

	// EXE forward path
	logic                   fwd_we;
	logic [`CPU_RIDX_W-1:0] fwd_reg;
	logic [`CPU_XLEN-1:0]   fwd_data;

	logic                   id_exe_en;
	logic                   id_exe_bubble;

	////////////////////
	// Stage handshake
	////////////////////

	// Hold freezes ID/EXE, a taken branch squashes the instruction in ID
	assign id_exe_en     = !hold;
	assign id_exe_bubble = redirect;

	reg_file u_reg_file (
		.clk     (clk),
		.rst     (rst),
		.ra_idx  (rf_ra_idx),
		.rb_idx  (rf_rb_idx),
		.we      (wb_valid),
		.w_idx   (wb_reg),
		.w_data  (wb_data),
		.ra_data (rf_ra_data),
		.rb_data (rf_rb_data)
	);

	decode_unit u_decode (
		.instr        (instr),
		.instr_valid  (instr_valid),
		.rf_ra_data   (rf_ra_data),
		.rf_rb_data   (rf_rb_data),
		.exe_fwd_we   (fwd_we),
		.exe_fwd_reg  (fwd_reg),
		.exe_fwd_data (fwd_data),
		.wb_we        (wb_valid),
		.wb_reg       (wb_reg),
		.wb_data      (wb_data),
		.rf_ra_idx    (rf_ra_idx),
		.rf_rb_idx    (rf_rb_idx),
		.alu_op       (id_alu_op),
		.rega         (id_rega),
		.regb         (id_regb),
		.imme         (id_imme),
		.use_imm      (id_use_imm),
		.sign_ext     (id_sign_ext),
		.is_branch    (id_is_branch),
		.branch_ne    (id_branch_ne),
		.dreg_we      (id_dreg_we),
		.dreg         (id_dreg)
	);

	id_exe_reg u_id_exe (
		.clk           (clk),
		.rst           (rst),
		.en            (id_exe_en),
		.bubble        (id_exe_bubble),
		.id_alu_op     (id_alu_op),
		.id_rega       (id_rega),
		.id_regb       (id_regb),
		.id_imme       (id_imme),
		.id_use_imm    (id_use_imm),
		.id_sign_ext   (id_sign_ext),
		.id_is_branch  (id_is_branch),
		.id_branch_ne  (id_branch_ne),
		.id_dreg_we    (id_dreg_we),
		.id_dreg       (id_dreg),
		.id_pc         (instr_pc),
		.exe_alu_op    (exe_alu_op),
		.exe_rega      (exe_rega),
		.exe_regb      (exe_regb),
		.exe_imme      (exe_imme),
		.exe_use_imm   (exe_use_imm),
		.exe_sign_ext  (exe_sign_ext),
		.exe_is_branch (exe_is_branch),
		.exe_branch_ne (exe_branch_ne),
		.exe_dreg_we   (exe_dreg_we),
		.exe_dreg      (exe_dreg),
		.exe_pc        (exe_pc)
	);

	exe_unit u_exe (
		.clk           (clk),
		.rst           (rst),
		.hold          (hold),
		.exe_alu_op    (exe_alu_op),
		.exe_rega      (exe_rega),
		.exe_regb      (exe_regb),
		.exe_imme      (exe_imme),
		.exe_use_imm   (exe_use_imm),
		.exe_sign_ext  (exe_sign_ext),
		.exe_is_branch (exe_is_branch),
		.exe_branch_ne (exe_branch_ne),
		.exe_dreg_we   (exe_dreg_we),
		.exe_dreg      (exe_dreg),
		.exe_pc        (exe_pc),
		.fwd_we        (fwd_we),
		.fwd_reg       (fwd_reg),
		.fwd_data      (fwd_data),
		.redirect      (redirect),
		.redirect_pc   (redirect_pc),
		.wb_valid      (wb_valid),
		.wb_reg        (wb_reg),
		.wb_data       (wb_data)
	);

endmodule

// File: verif/ref_model.svh
`ifndef REF_MODEL_SVH
`define REF_MODEL_SVH

////////////////////
// ISA model
////////////////////

// Architectural state where r0 is never written and stays zero
logic [31:0] model_regs [32];

task automatic reset_model_regs();
	for (int i = 0; i < 32; i++) begin
		model_regs[i] = '0;
	end
endtask

// Runs one instruction in program order
task automatic execute_instr(
	input  logic [31:0] ins,
	input  logic [31:0] pc,
	output logic        wr,
	output logic [4:0]  wr_reg,
	output logic [31:0] wr_data,
	output logic        br,
	output logic        br_taken,
	output logic [31:0] br_target
);
	logic [5:0]  op;
	logic [5:0]  fn;
	logic [4:0]  rs;
	logic [4:0]  rt;
	logic [4:0]  rd;
	logic [4:0]  sh;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] simm;
	logic [31:0] zimm;
	op   = ins[31:26];
	fn   = ins[5:0];
	rs   = ins[25:21];
	rt   = ins[20:16];
	rd   = ins[15:11];
	sh   = ins[10:6];
	a    = model_regs[rs];
	b    = model_regs[rt];
	simm = {{16{ins[15]}}, ins[15:0]};
	zimm = {16'h0000, ins[15:0]};
	wr       = 1'b0;
	wr_reg   = '0;
	wr_data  = '0;
	br       = 1'b0;
	br_taken = 1'b0;
	case (op)
		cpu_pkg::OP_RTYPE: begin
			wr     = 1'b1;
			wr_reg = rd;
			case (fn)
				cpu_pkg::FN_ADD: wr_data = a + b;
				cpu_pkg::FN_SUB: wr_data = a - b;
				cpu_pkg::FN_AND: wr_data = a & b;
				cpu_pkg::FN_OR:  wr_data = a | b;
				cpu_pkg::FN_XOR: wr_data = a ^ b;
				cpu_pkg::FN_SLT: wr_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
				cpu_pkg::FN_SLL: wr_data = b << sh;
				default:         wr = 1'b0;
			endcase
		end
		cpu_pkg::OP_ADDI: begin
			wr      = 1'b1;
			wr_reg  = rt;
			wr_data = a + simm;
		end
		cpu_pkg::OP_ORI: begin
			wr      = 1'b1;
			wr_reg  = rt;
			wr_data = a | zimm;
		end
		cpu_pkg::OP_LUI: begin
			wr      = 1'b1;
			wr_reg  = rt;
			wr_data = {ins[15:0], 16'h0000};
		end
		cpu_pkg::OP_BEQ: begin
			br       = 1'b1;
			br_taken = (a == b);
		end
		cpu_pkg::OP_BNE: begin
			br       = 1'b1;
			br_taken = (a != b);
		end
		default: begin
		end
	endcase
	// Word offset relative to the next instruction
	br_target = pc + 32'd4 + (simm << 2);
	if (wr && (wr_reg != 5'd0)) begin
		model_regs[wr_reg] = wr_data;
	end else begin
		wr = 1'b0;
	end
endtask

`endif

// File: verif/tb_pipe_core.sv
`include "cpu_settings.svh"

module tb_pipe_core;

	localparam int clk_half    = 20;
	localparam int prog_len    = 64;
	localparam int max_steps   = 400;
	localparam int run_limit   = 3000;
	localparam int drain_limit = 40;

	logic                   clk;
	logic                   rst;
	logic [31:0]            instr;
	logic [`CPU_XLEN-1:0]   instr_pc;
	logic                   instr_valid;
	logic                   hold;
	logic                   redirect;
	logic [`CPU_XLEN-1:0]   redirect_pc;
	logic                   wb_valid;
	logic [`CPU_RIDX_W-1:0] wb_reg;
	logic [`CPU_XLEN-1:0]   wb_data;

	logic [31:0] program_mem [prog_len];
	logic [4:0]  exp_reg_q [$];
	logic [31:0] exp_data_q [$];

	int          fetch_idx;
	int          cycle_no;
	int          steps;
	int          run_cycles;
	int          first_cap_cycle;
	logic        first_wb_seen;
	logic        pend_br;
	logic        pend_taken;
	logic [31:0] pend_target;
	int          data_errs;
	int          flow_errs;
	int          timeouts;

	`include "ref_model.svh"

	pipe_core u_dut (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_pc    (instr_pc),
		.instr_valid (instr_valid),
		.hold        (hold),
		.redirect    (redirect),
		.redirect_pc (redirect_pc),
		.wb_valid    (wb_valid),
		.wb_reg      (wb_reg),
		.wb_data     (wb_data)
	);

	initial begin
		clk = 1'b0;
		forever #(clk_half) clk = ~clk;
	end

	////////////////////
	// Program
	////////////////////

	function automatic logic [31:0] encode_rtype(input logic [5:0] fn, input logic [4:0] rs,
		input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] sh);
		logic [5:0] op;
		op = cpu_pkg::OP_RTYPE;
		return {op, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] encode_itype(input logic [5:0] op, input logic [4:0] rs,
		input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic build_program();
		int         kind;
		int         off;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] sh;
		logic [15:0] imm;
		logic [5:0] fn;
		for (int i = 0; i < prog_len; i++) begin
			kind = $urandom_range(0, 12);
			// Few registers so that neighbours depend on each other
			rs  = 5'($urandom_range(0, 7));
			rt  = 5'($urandom_range(0, 7));
			rd  = 5'($urandom_range(0, 7));
			sh  = 5'($urandom_range(0, 31));
			imm = 16'($urandom());
			case (kind)
				0: fn = cpu_pkg::FN_ADD;
				1: fn = cpu_pkg::FN_SUB;
				2: fn = cpu_pkg::FN_AND;
				3: fn = cpu_pkg::FN_OR;
				4: fn = cpu_pkg::FN_XOR;
				5: fn = cpu_pkg::FN_SLT;
				default: fn = cpu_pkg::FN_SLL;
			endcase
			if (kind <= 5) begin
				program_mem[i] = encode_rtype(fn, rs, rt, rd, 5'd0);
			end else if (kind == 6) begin
				program_mem[i] = encode_rtype(fn, 5'd0, rt, rd, sh);
			end else if (kind <= 8) begin
				program_mem[i] = encode_itype(cpu_pkg::OP_ADDI, rs, rt, imm);
			end else if (kind == 9) begin
				program_mem[i] = encode_itype(cpu_pkg::OP_ORI, rs, rt, imm);
			end else if (kind == 10) begin
				program_mem[i] = encode_itype(cpu_pkg::OP_LUI, 5'd0, rt, imm);
			end else begin
				// Short hop that never lands before word 0
				off = int'($urandom_range(0, 10)) - 5;
				if (i + 1 + off < 0) begin
					off = 0;
				end
				if ($urandom_range(0, 2) == 0) begin
					rt = rs;
				end
				program_mem[i] = encode_itype((kind == 11) ? cpu_pkg::OP_BEQ : cpu_pkg::OP_BNE,
					rs, rt, 16'(off));
			end
		end
		// Known writer at word 0 for the latency check
		program_mem[0] = encode_itype(cpu_pkg::OP_ADDI, 5'd0, 5'd1, 16'h8123);
	endtask

	////////////////////
	// Per-cycle checks
	////////////////////

	task automatic check_writeback();
		logic [4:0]  e_reg;
		logic [31:0] e_data;
		if (wb_valid === 1'b1) begin
			if (!first_wb_seen) begin
				first_wb_seen = 1'b1;
				if (cycle_no != first_cap_cycle + 2) begin
					flow_errs++;
					$display("[FAIL] %0t: first write-back %0d edges after capture, expected 2",
						$time, cycle_no - first_cap_cycle);
				end
			end
			if (exp_reg_q.size() == 0) begin
				flow_errs++;
				$display("[FAIL] %0t: unexpected write-back r%0d = %h", $time, wb_reg, wb_data);
			end else begin
				e_reg  = exp_reg_q.pop_front();
				e_data = exp_data_q.pop_front();
				if ((wb_reg !== e_reg) || (wb_data !== e_data)) begin
					data_errs++;
					$display("[FAIL] %0t: write-back r%0d = %h, expected r%0d = %h",
						$time, wb_reg, wb_data, e_reg, e_data);
				end
			end
		end else if (wb_valid !== 1'b0) begin
			flow_errs++;
			$display("[FAIL] %0t: wb_valid is unknown", $time);
		end
	endtask

	// One fetch slot driven on the falling edge
	task automatic step_cycle(input logic want_valid, input logic want_hold);
		logic [31:0] cur_instr;
		logic        in_range;
		logic        seen_redirect;
		logic [31:0] seen_target;
		logic        resolved;
		logic        squash;
		logic        m_wr;
		logic [4:0]  m_reg;
		logic [31:0] m_data;
		logic        m_br;
		logic        m_taken;
		logic [31:0] m_target;
		@(negedge clk);
		cycle_no++;
		check_writeback();
		in_range    = (fetch_idx < prog_len);
		cur_instr   = in_range ? program_mem[fetch_idx] : 32'h0;
		hold        = want_hold;
		instr_valid = want_valid && in_range;
		instr       = instr_valid ? cur_instr : $urandom();
		instr_pc    = fetch_idx * 4;
		// Redirect depends on hold, so look once it has settled
		#(clk_half / 2);
		seen_redirect = redirect;
		seen_target   = redirect_pc;
		resolved      = pend_br && !hold;
		squash        = resolved && pend_taken;
		if (resolved) begin
			pend_br = 1'b0;
			if (seen_redirect !== pend_taken) begin
				flow_errs++;
				$display("[FAIL] %0t: redirect is %b, branch taken is %b",
					$time, seen_redirect, pend_taken);
			end else if (pend_taken && (seen_target !== pend_target)) begin
				flow_errs++;
				$display("[FAIL] %0t: redirect_pc is %h, expected %h",
					$time, seen_target, pend_target);
			end
		end else if (seen_redirect !== 1'b0) begin
			flow_errs++;
			$display("[FAIL] %0t: redirect with no branch to resolve", $time);
		end
		if (squash) begin
			fetch_idx = int'(pend_target >> 2);
		end else if (!hold && instr_valid) begin
			execute_instr(cur_instr, fetch_idx * 4, m_wr, m_reg, m_data, m_br, m_taken,
				m_target);
			if (m_wr) begin
				exp_reg_q.push_back(m_reg);
				exp_data_q.push_back(m_data);
			end
			if (m_br) begin
				pend_br     = 1'b1;
				pend_taken  = m_taken;
				pend_target = m_target;
			end
			if (first_cap_cycle < 0) begin
				first_cap_cycle = cycle_no;
			end
			fetch_idx++;
			steps++;
		end
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		int drain_n;
		rst             = 1'b1;
		instr           = '0;
		instr_pc        = '0;
		instr_valid     = 1'b0;
		hold            = 1'b0;
		fetch_idx       = 0;
		cycle_no        = 0;
		steps           = 0;
		run_cycles      = 0;
		first_cap_cycle = -1;
		first_wb_seen   = 1'b0;
		pend_br         = 1'b0;
		pend_taken      = 1'b0;
		pend_target     = '0;
		data_errs       = 0;
		flow_errs       = 0;
		timeouts        = 0;
		drain_n         = 0;
		void'($urandom(32'hc7c760fa));
		build_program();
		reset_model_regs();

		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
		end
		@(negedge clk);
		if ((wb_valid !== 1'b0) || (redirect !== 1'b0)) begin
			flow_errs++;
			$display("[FAIL] %0t: wb_valid or redirect high during reset", $time);
		end
		rst = 1'b0;

		// Idle slots where nothing may come out yet
		for (int i = 0; i < 2; i++) begin
			step_cycle(1'b0, 1'b0);
		end

		while ((fetch_idx < prog_len) && (steps < max_steps) && (run_cycles < run_limit)) begin
			step_cycle((run_cycles < 4) || ($urandom_range(0, 7) != 0),
				(run_cycles >= 4) && ($urandom_range(0, 4) == 0));
			run_cycles++;
		end
		if (run_cycles >= run_limit) begin
			timeouts++;
			$display("Timeout: program did not finish within %0d cycles", run_limit);
		end

		while (((exp_reg_q.size() > 0) || pend_br) && (drain_n < drain_limit)) begin
			step_cycle(1'b0, 1'b0);
			drain_n++;
		end
		if ((exp_reg_q.size() > 0) || pend_br) begin
			timeouts++;
			$display("Timeout: %0d write-backs still missing after %0d cycles",
				exp_reg_q.size(), drain_limit);
		end
		// Catch stray late writes
		for (int i = 0; i < 4; i++) begin
			step_cycle(1'b0, 1'b0);
		end

		$display("Steps %0d, errors: data %0d, flow %0d, timeout %0d",
			steps, data_errs, flow_errs, timeouts);
		if ((data_errs + flow_errs + timeouts) == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+include
+incdir+verif
source/cpu_pkg.sv
source/reg_file.sv
source/decode_unit.sv
source/id_exe_reg.sv
source/exe_unit.sv
source/pipe_core.sv
verif/tb_pipe_core.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary -j 0
TOP       := tb_pipe_core
FILELIST  := filelist.f

SRCS := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS := include/cpu_settings.svh verif/ref_model.svh
BIN  := obj_dir/V$(TOP)
LOG  := sim.log

.PHONY: all run clean

all: $(BIN)

$(BIN): $(FILELIST) $(SRCS) $(HDRS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "STATUS: FAIL" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
